//--- common/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// geometry
// ------------------------------
`define BW_WORD_ADDR			16			// word address width
`define BW_BLOCK				2			// word offset, 4 words per block
`define CACHE_BLOCK_CAPACITY	16			// blocks in the cache

// ceiling log2 for elaboration-time sizing
// ------------------------------
`define CLOG2(x) \
	(((x) <= 1)    ? 0 : \
	 ((x) <= 2)    ? 1 : \
	 ((x) <= 4)    ? 2 : \
	 ((x) <= 8)    ? 3 : \
	 ((x) <= 16)   ? 4 : \
	 ((x) <= 32)   ? 5 : \
	 ((x) <= 64)   ? 6 : \
	 ((x) <= 128)  ? 7 : \
	 ((x) <= 256)  ? 8 : \
	 ((x) <= 512)  ? 9 : \
	 ((x) <= 1024) ? 10 : 11)

`endif

//--- common/cache_pkg.sv
`include "cache_defs.svh"
`default_nettype none

package cache_pkg;

	// derived geometry
	// ------------------------------
	localparam int N_WAYS = 4;
	localparam int BW_GRP = `CLOG2(`CACHE_BLOCK_CAPACITY) - `CLOG2(N_WAYS);	// sets = blocks / ways
	localparam int BW_TAG = `BW_WORD_ADDR - BW_GRP - `BW_BLOCK;				// what is left on top

	typedef logic [`CLOG2(N_WAYS)-1:0] way_t;

	typedef struct packed {
		logic [BW_TAG-1:0]		tag;
		logic [BW_GRP-1:0]		group;		// set index
		logic [`BW_BLOCK-1:0]	word;		// offset in block
	} cache_addr_fields_t;

	// same word, seen whole or split
	typedef union packed {
		logic [`BW_WORD_ADDR-1:0]	raw;
		cache_addr_fields_t			fields;
	} cache_addr_u;

	typedef enum logic [2:0] {
		IDLE, LOOKUP, HIT, WB_REQ, WB_DATA, FILL_REQ, FILL_DATA, DONE
	} ctrl_state_t;

	typedef enum logic [1:0] {
		HITS, MISSES, WRITEBACKS, CLEAR		// comm_i[1:0]
	} comm_sel_t;

endpackage

`default_nettype wire

//--- common/tag_if.sv
`timescale 1ns/1ns
`default_nettype none

interface tag_if;

	// controller side
	logic						lookup_o;		// one-cycle compare strobe
	cache_pkg::cache_addr_u		addr;
	logic						fill_o;			// install tag in victim way
	logic						dirty_set_o;	// mark matching way dirty
	logic						touch_o;		// plru update for matching way
	cache_pkg::ctrl_state_t		state;

	// tag memory side
	logic						hit;
	cache_pkg::way_t			hit_way;
	cache_pkg::way_t			victim_way;
	logic						victim_dirty;
	logic [cache_pkg::BW_TAG-1:0]	victim_tag;

	modport ctrl (
		output lookup_o, addr, fill_o, dirty_set_o, touch_o, state,
		input  hit, hit_way, victim_way, victim_dirty, victim_tag
	);

	modport tagmem (
		input  lookup_o, addr, fill_o, dirty_set_o, touch_o, state,
		output hit, hit_way, victim_way, victim_dirty, victim_tag
	);

endinterface

`default_nettype wire

//--- design/cache_performance_controller.sv
`timescale 1ns/1ns
`default_nettype none

module cache_performance_controller (
	input  wire			clock_i,
	input  wire			rst_i,
	input  wire			flag_hit_i,
	input  wire			flag_miss_i,
	input  wire			flag_writeback_i,
	input  wire [31:0]	comm_i,			// [1:0] select, [31] clear strobe
	output logic [31:0]	comm_o
);

	// counters
	// ------------------------------
	logic [31:0]			cnt_q [3];		// hits, misses, writebacks
	logic [2:0]				flags;
	cache_pkg::comm_sel_t	sel;
	logic					clear;

	assign flags = {flag_writeback_i, flag_miss_i, flag_hit_i};
	assign sel   = cache_pkg::comm_sel_t'(comm_i[1:0]);
	assign clear = sel == cache_pkg::CLEAR && comm_i[31];

	always_ff @(posedge clock_i) begin
		for (int i = 0; i < 3; i++) begin
			if (rst_i || clear)
				cnt_q[i] <= '0;
			else if (flags[i] && cnt_q[i] != '1)
				cnt_q[i] <= cnt_q[i] + 32'd1;	// sticks at max
		end
	end

	// readback
	always_comb begin
		case (sel)
			cache_pkg::HITS:		comm_o = cnt_q[0];
			cache_pkg::MISSES:		comm_o = cnt_q[1];
			cache_pkg::WRITEBACKS:	comm_o = cnt_q[2];
			default:				comm_o = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- cache_4way/tag_memory_4way.sv
`timescale 1ns/1ns
`default_nettype none

module tag_memory_4way (
	input  wire		clock_i,
	input  wire		rst_i,
	tag_if.tagmem	tag
);

	localparam int N_WAYS = cache_pkg::N_WAYS;
	localparam int N_SETS = 2 ** cache_pkg::BW_GRP;

	// storage
	// ------------------------------
	logic [cache_pkg::BW_TAG-1:0]	tags_q [N_SETS][N_WAYS];	// no reset, gated by valid
	logic [N_WAYS-1:0]				valid_q [N_SETS];
	logic [N_WAYS-1:0]				dirty_q [N_SETS];
	logic [2:0]						plru_q [N_SETS];			// [0] root, [1] ways 0/1, [2] ways 2/3

	logic [cache_pkg::BW_GRP-1:0]	grp;
	logic [N_WAYS-1:0]				match;
	cache_pkg::way_t				match_way;
	cache_pkg::way_t				plru_way;
	cache_pkg::way_t				victim;
	logic							has_invalid;

	assign grp = tag.addr.fields.group;

	// compare all ways
	// ------------------------------
	always_comb begin
		match_way   = '0;
		victim      = '0;
		has_invalid = 1'b0;
		for (int w = N_WAYS - 1; w >= 0; w--) begin	// downward so lowest wins
			match[w] = valid_q[grp][w] && (tags_q[grp][w] == tag.addr.fields.tag);
			if (match[w])
				match_way = cache_pkg::way_t'(w);
			if (!valid_q[grp][w]) begin
				victim      = cache_pkg::way_t'(w);
				has_invalid = 1'b1;
			end
		end
		if (!has_invalid)
			victim = plru_way;
	end

	// walk the tree toward the older side
	assign plru_way = plru_q[grp][0] ? {1'b1, plru_q[grp][2]} : {1'b0, plru_q[grp][1]};

	assign tag.hit          = tag.lookup_o && |match;	// only meaningful on the strobe
	assign tag.hit_way      = match_way;
	assign tag.victim_way   = victim;
	assign tag.victim_dirty = valid_q[grp][victim] && dirty_q[grp][victim];
	assign tag.victim_tag   = tags_q[grp][victim];

	// updates
	// ------------------------------
	always_ff @(posedge clock_i) begin
		if (rst_i) begin
			for (int s = 0; s < N_SETS; s++) begin
				valid_q[s] <= '0;		// all lines invalid in one cycle
				dirty_q[s] <= '0;
				plru_q[s]  <= '0;
			end
		end else begin
			if (tag.fill_o) begin
				valid_q[grp][victim] <= 1'b1;
				dirty_q[grp][victim] <= 1'b0;	// fresh copy of memory
			end
			if (tag.dirty_set_o)
				dirty_q[grp][match_way] <= 1'b1;
			if (tag.touch_o) begin
				plru_q[grp][0] <= ~match_way[1];			// point root away
				if (match_way[1])
					plru_q[grp][2] <= ~match_way[0];
				else
					plru_q[grp][1] <= ~match_way[0];
			end
		end
	end

	always_ff @(posedge clock_i) begin
		if (tag.fill_o)
			tags_q[grp][victim] <= tag.addr.fields.tag;
	end

	// checks
	// ------------------------------
	a_one_match: assert property (@(posedge clock_i) disable iff (rst_i)
		$onehot0(match));								// no duplicate tags in a set
	a_hit_resident: assert property (@(posedge clock_i) disable iff (rst_i)
		tag.state == cache_pkg::HIT |-> |match);		// dirty and touch need a live way

endmodule

`default_nettype wire

//--- cache_4way/cache_4way_controller.sv
`timescale 1ns/1ns
`default_nettype none
`include "cache_defs.svh"

module cache_4way_controller (
	input  wire						clock_i,
	input  wire						rst_i,
	input  wire						en_i,
	input  wire						core_req_i,
	input  wire						core_rw_i,
	input  wire cache_pkg::cache_addr_u	core_add_i,
	input  wire [31:0]				core_data_i,
	input  wire						ready_req_i,
	input  wire						ready_write_i,
	input  wire						ready_read_i,
	input  wire [31:0]				data_i,
	output logic					core_done_o,
	output logic [31:0]				core_data_o,
	output logic					hit_o,
	output logic					req_o,
	output logic					req_block_o,
	output logic					rw_o,
	output logic [`BW_WORD_ADDR-1:0]	add_o,
	output logic					write_o,
	output logic					read_o,
	output logic [31:0]				data_o,
	output logic					flag_hit_o,
	output logic					flag_miss_o,
	output logic					flag_writeback_o,
	tag_if.ctrl						tag
);

	localparam int DEPTH   = `CACHE_BLOCK_CAPACITY << `BW_BLOCK;	// 64 words
	localparam int BW_DIDX = `CLOG2(DEPTH);

	// state
	// ------------------------------
	cache_pkg::ctrl_state_t		state_q;
	cache_pkg::ctrl_state_t		state_d;
	logic						missed_q;		// this request missed at least once
	logic [`BW_BLOCK-1:0]		cnt_q;			// word counter for block transfers
	cache_pkg::way_t			way_q;			// hit way or refill victim
	logic [31:0]				data_mem [DEPTH];	// {set, way, word}
	logic [BW_DIDX-1:0]			core_idx;
	logic [BW_DIDX-1:0]			xfer_idx;
	logic						xfer_last;

	assign core_idx  = {core_add_i.fields.group, way_q, core_add_i.fields.word};
	assign xfer_idx  = {core_add_i.fields.group, way_q, cnt_q};
	assign xfer_last = &cnt_q;

	// tag memory drive
	assign tag.addr        = core_add_i;
	assign tag.state       = state_q;
	assign tag.lookup_o    = state_q == cache_pkg::LOOKUP;
	assign tag.touch_o     = state_q == cache_pkg::HIT;
	assign tag.dirty_set_o = state_q == cache_pkg::HIT && core_rw_i;
	assign tag.fill_o      = state_q == cache_pkg::FILL_DATA && ready_read_i && xfer_last;

	// next state
	// ------------------------------
	always_comb begin
		state_d = state_q;
		case (state_q)
			cache_pkg::IDLE:		if (core_req_i && en_i) state_d = cache_pkg::LOOKUP;
			cache_pkg::LOOKUP: begin
				if (tag.hit)
					state_d = cache_pkg::HIT;
				else if (tag.victim_dirty)
					state_d = cache_pkg::WB_REQ;	// evict first
				else
					state_d = cache_pkg::FILL_REQ;
			end
			cache_pkg::HIT:			state_d = cache_pkg::DONE;
			cache_pkg::WB_REQ:		if (ready_req_i) state_d = cache_pkg::WB_DATA;
			cache_pkg::WB_DATA:		if (ready_write_i && xfer_last) state_d = cache_pkg::FILL_REQ;
			cache_pkg::FILL_REQ:	if (ready_req_i) state_d = cache_pkg::FILL_DATA;
			cache_pkg::FILL_DATA:	if (ready_read_i && xfer_last) state_d = cache_pkg::LOOKUP;	// replay
			default:				state_d = cache_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clock_i) begin
		if (rst_i) begin
			state_q  <= cache_pkg::IDLE;
			missed_q <= 1'b0;
			cnt_q    <= '0;
		end else begin
			state_q <= state_d;
			if (state_q == cache_pkg::LOOKUP && !tag.hit)
				missed_q <= 1'b1;
			else if (state_q == cache_pkg::DONE)
				missed_q <= 1'b0;
			if ((write_o && ready_write_i) || (read_o && ready_read_i))
				cnt_q <= cnt_q + 1'b1;			// wraps back to 0 after word 3
		end
	end

	// data array and way latch
	// ------------------------------
	always_ff @(posedge clock_i) begin
		if (state_q == cache_pkg::LOOKUP)
			way_q <= tag.hit ? tag.hit_way : tag.victim_way;
		if (state_q == cache_pkg::HIT) begin
			if (core_rw_i)
				data_mem[core_idx] <= core_data_i;
			core_data_o <= core_rw_i ? core_data_i : data_mem[core_idx];
		end
		if (read_o && ready_read_i)
			data_mem[xfer_idx] <= data_i;		// refill word
	end

	// memory side
	// ------------------------------
	assign req_o       = state_q == cache_pkg::WB_REQ || state_q == cache_pkg::FILL_REQ;
	assign rw_o        = state_q == cache_pkg::WB_REQ;
	assign req_block_o = 1'b1;					// always whole blocks
	assign add_o       = rw_o ? {tag.victim_tag, core_add_i.fields.group, {`BW_BLOCK{1'b0}}}
	                          : {core_add_i.fields.tag, core_add_i.fields.group, {`BW_BLOCK{1'b0}}};
	assign write_o     = state_q == cache_pkg::WB_DATA;
	assign read_o      = state_q == cache_pkg::FILL_DATA;
	assign data_o      = data_mem[xfer_idx];	// victim word by offset

	// core side and flags
	assign core_done_o      = state_q == cache_pkg::DONE;
	assign hit_o            = core_done_o && !missed_q;
	assign flag_hit_o       = tag.lookup_o && tag.hit && !missed_q;	// replay not counted
	assign flag_miss_o      = tag.lookup_o && !tag.hit && !missed_q;
	assign flag_writeback_o = state_q == cache_pkg::WB_REQ && ready_req_i;

	// checks
	// ------------------------------
	a_no_rw_overlap: assert property (@(posedge clock_i) disable iff (rst_i)
		!(write_o && read_o));
	a_done_pulse: assert property (@(posedge clock_i) disable iff (rst_i)
		core_done_o |=> !core_done_o);			// single-cycle completion

endmodule

`default_nettype wire

//--- cache_4way/cache_4way.sv
`timescale 1ns/1ns
`default_nettype none
`include "cache_defs.svh"

module cache_4way (
	// system
	input  wire						clock_i,
	input  wire						rst_i,
	input  wire						en_i,			// cache enabled by mem controller
	input  wire [31:0]				comm_i,
	output wire [31:0]				comm_o,

	// core
	input  wire						core_req_i,
	input  wire						core_rw_i,		// 1 write
	input  wire [`BW_WORD_ADDR-1:0]	core_add_i,
	input  wire [31:0]				core_data_i,
	output wire						core_done_o,
	output wire [31:0]				core_data_o,
	output wire						hit_o,

	// memory command and buffer
	input  wire						ready_req_i,
	input  wire						ready_write_i,
	input  wire						ready_read_i,
	input  wire [31:0]				data_i,
	output wire						req_o,
	output wire						req_block_o,
	output wire						rw_o,			// 1 write-back
	output wire [`BW_WORD_ADDR-1:0]	add_o,
	output wire						write_o,
	output wire						read_o,
	output wire [31:0]				data_o
);

	// address and flags
	// ------------------------------
	cache_pkg::cache_addr_u	core_addr;
	logic					hit_flag;
	logic					miss_flag;
	logic					wb_flag;

	assign core_addr.raw = core_add_i;

	tag_if tag_bus ();

	tag_memory_4way tag_mem_inst (
		.clock_i			(clock_i),
		.rst_i				(rst_i),
		.tag				(tag_bus)
	);

	cache_4way_controller cache_contr_inst (
		.clock_i			(clock_i),
		.rst_i				(rst_i),
		.en_i				(en_i),
		.core_req_i			(core_req_i),
		.core_rw_i			(core_rw_i),
		.core_add_i			(core_addr),
		.core_data_i		(core_data_i),
		.ready_req_i		(ready_req_i),
		.ready_write_i		(ready_write_i),
		.ready_read_i		(ready_read_i),
		.data_i				(data_i),
		.core_done_o		(core_done_o),
		.core_data_o		(core_data_o),
		.hit_o				(hit_o),
		.req_o				(req_o),
		.req_block_o		(req_block_o),
		.rw_o				(rw_o),
		.add_o				(add_o),
		.write_o			(write_o),
		.read_o				(read_o),
		.data_o				(data_o),
		.flag_hit_o			(hit_flag),
		.flag_miss_o		(miss_flag),
		.flag_writeback_o	(wb_flag),
		.tag				(tag_bus)
	);

	cache_performance_controller perf_cont_inst (
		.clock_i			(clock_i),
		.rst_i				(rst_i),
		.flag_hit_i			(hit_flag),
		.flag_miss_i		(miss_flag),
		.flag_writeback_i	(wb_flag),
		.comm_i				(comm_i),
		.comm_o				(comm_o)
	);

endmodule

`default_nettype wire

//--- tests/mem_model.sv
`timescale 1ns/1ns
`default_nettype none
`include "cache_defs.svh"

module mem_model (
	input  wire							clock_i,
	input  wire							rst_i,
	input  wire							req_i,			// block command from cache
	input  wire [`BW_WORD_ADDR-1:0]		add_i,			// block base address
	input  wire							write_i,
	input  wire							read_i,
	input  wire [31:0]					data_i,			// write-back word
	output logic						ready_req_o,
	output logic						ready_write_o,
	output logic						ready_read_o,
	output logic [31:0]					data_o			// refill word
);

	// storage and transfer state
	// ------------------------------
	logic [31:0]				mem [65536];
	logic [`BW_WORD_ADDR-1:0]	base_q;					// latched on command accept
	logic [`BW_BLOCK-1:0]		cnt_q;					// word offset in block
	int							seed = 32'hc247;

	initial begin
		for (int a = 0; a < 65536; a++)
			mem[a] <= 32'(a[15:0] ^ 16'h5a5a);			// address-derived pattern
	end

	assign data_o = mem[{base_q[`BW_WORD_ADDR-1:`BW_BLOCK], cnt_q}];

	always @(posedge clock_i) begin
		logic [31:0] roll;
		roll = $random(seed);
		if (rst_i) begin
			ready_req_o   <= 1'b0;
			ready_write_o <= 1'b0;
			ready_read_o  <= 1'b0;
			base_q        <= '0;
			cnt_q         <= '0;
		end else begin
			ready_req_o   <= roll[1:0] != 2'b00;		// ready about 3 cycles in 4
			ready_write_o <= roll[3:2] != 2'b00;
			ready_read_o  <= roll[5:4] != 2'b00;
			if (req_i && ready_req_o) begin
				base_q <= add_i;
				cnt_q  <= '0;
			end
			if (write_i && ready_write_o) begin
				mem[{base_q[`BW_WORD_ADDR-1:`BW_BLOCK], cnt_q}] <= data_i;
				cnt_q <= cnt_q + 1'b1;
			end
			if (read_i && ready_read_o)
				cnt_q <= cnt_q + 1'b1;					// next refill word
		end
	end

endmodule

`default_nettype wire

//--- tests/tb_cache_4way.sv
`timescale 1ns/1ns
`default_nettype none
`include "cache_defs.svh"

module tb_cache_4way;

	typedef struct packed {
		logic						rw;				// 1 write
		logic [`BW_WORD_ADDR-1:0]	addr;
		logic [31:0]				wdata;
		logic [31:0]				exp_data;
		logic						exp_hit;
		logic						exp_wb;			// evicts a dirty block
	} access_t;

	// dut signals
	// ------------------------------
	logic						clock_i;
	logic						rst_i;
	logic						en_i;
	logic						core_req_i;
	logic						core_rw_i;
	logic [`BW_WORD_ADDR-1:0]	core_add_i;
	logic [31:0]				core_data_i;
	logic [31:0]				comm_i;
	logic						ready_req_i;
	logic						ready_write_i;
	logic						ready_read_i;
	logic [31:0]				data_i;
	logic						core_done_o;
	logic [31:0]				core_data_o;
	logic						hit_o;
	logic [31:0]				comm_o;
	logic						req_o;
	logic						req_block_o;
	logic						rw_o;
	logic [`BW_WORD_ADDR-1:0]	add_o;
	logic						write_o;
	logic						read_o;
	logic [31:0]				data_o;

	string						name_q[$];
	access_t					access_q[$];

	cache_4way UUT (
		.clock_i(clock_i), .rst_i(rst_i), .en_i(en_i), .comm_i(comm_i), .comm_o(comm_o),
		.core_req_i(core_req_i), .core_rw_i(core_rw_i), .core_add_i(core_add_i),
		.core_data_i(core_data_i), .core_done_o(core_done_o), .core_data_o(core_data_o),
		.hit_o(hit_o), .ready_req_i(ready_req_i), .ready_write_i(ready_write_i),
		.ready_read_i(ready_read_i), .data_i(data_i), .req_o(req_o),
		.req_block_o(req_block_o), .rw_o(rw_o), .add_o(add_o), .write_o(write_o),
		.read_o(read_o), .data_o(data_o)
	);

	mem_model mem_inst (
		.clock_i(clock_i), .rst_i(rst_i), .req_i(req_o), .add_i(add_o),
		.write_i(write_o), .read_i(read_o), .data_i(data_o),
		.ready_req_o(ready_req_i), .ready_write_o(ready_write_i),
		.ready_read_o(ready_read_i), .data_o(data_i)
	);

	initial begin
		clock_i = 1'b0;
		forever #2 clock_i = ~clock_i;				// 4 ns period
	end

	// compare tasks
	// ------------------------------
	task automatic check_word(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Error %s: expected %h, actual %h", name, expected, actual);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_hit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("Error %s: expected hit %b, actual hit %b", name, expected, actual);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("Error %s: expected %b, actual %b", name, expected, actual);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_count(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Error %s: expected %0d, actual %0d", name, expected, actual);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	// stimulus table
	// ------------------------------
	function automatic void add_entry(input string name, input logic rw,
			input logic [`BW_WORD_ADDR-1:0] addr, input logic [31:0] wdata,
			input logic [31:0] exp_data, input logic exp_hit, input logic exp_wb);
		access_t entry;
		entry = '{rw, addr, wdata, exp_data, exp_hit, exp_wb};
		name_q.push_back(name);
		access_q.push_back(entry);
	endfunction

	// all in set 1, memory word = address ^ 5a5a
	function automatic void build_table();
		add_entry("cold_read_miss",   1'b0, 16'h0014, 32'h0, 32'h0000_5a4e, 1'b0, 1'b0);
		add_entry("read_hit",         1'b0, 16'h0014, 32'h0, 32'h0000_5a4e, 1'b1, 1'b0);
		add_entry("write_hit",        1'b1, 16'h0015, 32'hdead_beef, 32'hdead_beef, 1'b1, 1'b0);
		add_entry("write_readback",   1'b0, 16'h0015, 32'h0, 32'hdead_beef, 1'b1, 1'b0);
		add_entry("same_block_word",  1'b0, 16'h0016, 32'h0, 32'h0000_5a4c, 1'b1, 1'b0);
		add_entry("fill_way1",        1'b0, 16'h0024, 32'h0, 32'h0000_5a7e, 1'b0, 1'b0);
		add_entry("fill_way2",        1'b0, 16'h0034, 32'h0, 32'h0000_5a6e, 1'b0, 1'b0);
		add_entry("write_miss_way3",  1'b1, 16'h0045, 32'hcafe_f00d, 32'hcafe_f00d, 1'b0, 1'b0);
		add_entry("evict_plru_way0",  1'b0, 16'h0054, 32'h0, 32'h0000_5a0e, 1'b0, 1'b1);
		add_entry("reread_first_tag", 1'b0, 16'h0015, 32'h0, 32'hdead_beef, 1'b0, 1'b0);
		add_entry("hit_way1",         1'b0, 16'h0027, 32'h0, 32'h0000_5a7d, 1'b1, 1'b0);
		add_entry("evict_dirty_way3", 1'b0, 16'h0064, 32'h0, 32'h0000_5a3e, 1'b0, 1'b1);
		add_entry("reread_written",   1'b0, 16'h0045, 32'h0, 32'hcafe_f00d, 1'b0, 1'b0);
		add_entry("hit_refilled",     1'b0, 16'h0046, 32'h0, 32'h0000_5a1c, 1'b1, 1'b0);
	endfunction

	// one core request, done sampled at negedge
	task automatic run_access(input string name, input access_t acc);
		int		cycles;
		logic	wb_seen;
		cycles  = 0;
		wb_seen = 1'b0;
		@(posedge clock_i);
		core_req_i  <= 1'b1;
		core_rw_i   <= acc.rw;
		core_add_i  <= acc.addr;
		core_data_i <= acc.wdata;
		@(negedge clock_i);
		while (!core_done_o) begin
			cycles++;								// edges since the sampling edge
			if (cycles > 200) begin
				$display("%s: core request never completed", name);
				$display("SIMULATION FAILED");
				$fatal(1);
			end
			if (req_o) begin
				check_bit({name, "_req_block"}, 1'b1, req_block_o);
				check_bit({name, "_rw"}, acc.exp_wb && !wb_seen, rw_o);	// write-back goes first
			end
			if (write_o)
				wb_seen = 1'b1;
			@(negedge clock_i);
		end
		if (!acc.rw)
			check_word(name, acc.exp_data, core_data_o);	// read data only
		check_hit(name, acc.exp_hit, hit_o);
		check_bit({name, "_writeback"}, acc.exp_wb, wb_seen);
		if (acc.exp_hit)
			check_count({name, "_latency"}, 32'd3, cycles);
		@(posedge clock_i);
		core_req_i <= 1'b0;
	endtask

	task automatic read_counter(input cache_pkg::comm_sel_t sel, output logic [31:0] value);
		@(posedge clock_i);
		comm_i <= {30'd0, sel};
		@(negedge clock_i);
		value = comm_o;								// combinational readback
	endtask

	// main sequence
	// ------------------------------
	initial begin
		int				hits;
		int				misses;
		int				wbs;
		logic [31:0]	value;
		hits        = 0;
		misses      = 0;
		wbs         = 0;
		rst_i       = 1'b1;
		en_i        = 1'b1;
		core_req_i  = 1'b0;
		core_rw_i   = 1'b0;
		core_add_i  = '0;
		core_data_i = '0;
		comm_i      = '0;
		build_table();
		repeat (3) @(posedge clock_i);
		rst_i <= 1'b0;
		@(negedge clock_i);
		check_hit("reset_outputs", 1'b0, core_done_o | hit_o | req_o | write_o | read_o);

		for (int i = 0; i < access_q.size(); i++) begin
			run_access(name_q[i], access_q[i]);
			if (access_q[i].exp_hit)
				hits++;
			else
				misses++;
			if (access_q[i].exp_wb)
				wbs++;
		end

		read_counter(cache_pkg::HITS, value);
		check_count("hit_count", hits, value);
		read_counter(cache_pkg::MISSES, value);
		check_count("miss_count", misses, value);
		read_counter(cache_pkg::WRITEBACKS, value);
		check_count("writeback_count", wbs, value);

		@(posedge clock_i);
		comm_i <= {1'b1, 29'd0, cache_pkg::CLEAR};	// clear strobe
		read_counter(cache_pkg::HITS, value);
		check_count("hit_count_cleared", 32'd0, value);
		read_counter(cache_pkg::MISSES, value);
		check_count("miss_count_cleared", 32'd0, value);
		read_counter(cache_pkg::WRITEBACKS, value);
		check_count("writeback_count_cleared", 32'd0, value);

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+common
common/cache_pkg.sv
common/tag_if.sv
design/cache_performance_controller.sv
cache_4way/tag_memory_4way.sv
cache_4way/cache_4way_controller.sv
cache_4way/cache_4way.sv
tests/mem_model.sv
tests/tb_cache_4way.sv

//--- run.sh
#!/bin/sh
# build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module tb_cache_4way -f vlog.f -o sim_cache_4way
./obj_dir/sim_cache_4way
